// ==== Makefile ====
# Verilator simulation of the LCD output subsystem

VERILATOR ?= verilator
TOP       := lcd_display_tb
FILELIST  := lcd_display_top.f
VFLAGS    := --binary --timing --timescale 1ns/1ps -j 0
MDIR      := obj_dir

BIN       := $(MDIR)/V$(TOP)
SRCS      := $(wildcard hdl/*.sv hdl/*.svh test/*.sv)

.PHONY: all run clean

all: $(BIN)

# rebuild only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(MDIR) -f $(FILELIST)

# exit status is nonzero when the testbench stops on $fatal
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(MDIR)

// ==== hdl/lcd_cfg.svh ====
`ifndef LCD_CFG_SVH
`define LCD_CFG_SVH

// default raster is 800x600@60, 40 MHz pixel clock
// line = 128 + 88 + 800 + 40 = 1056 clocks
// frame = 4 + 23 + 600 + 1 = 628 lines

// horizontal, in pixel clocks
`define LCD_H_SYNC   128 // hsync low width
`define LCD_H_BACK   88  // back porch after sync
`define LCD_H_DISP   800 // visible pixels per line
`define LCD_H_FRONT  40  // front porch before next sync

// vertical, in lines
`define LCD_V_SYNC   4   // vsync low width
`define LCD_V_BACK   23  // back porch lines
`define LCD_V_DISP   600 // visible lines per frame
`define LCD_V_FRONT  1   // front porch lines

// coords lead lcd_en by the pattern source latency
`define LCD_AHEAD    1   // one register stage in pattern_gen

// colour bars
`define LCD_BAR_COUNT 8  // entries in the bar table
`define LCD_BAR_LOG2  3  // x is scaled by the bar count via shift

// grid lines every 2**n pixels
`define LCD_GRID_LOG2 4  // 16 pixel pitch

// widths shared by the package types
`define LCD_RGB_W    24  // 8:8:8 pixel
`define LCD_COORD_W  12  // enough for 4095 clocks per line

`endif

// ==== hdl/lcd_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_display_top
#(
	parameter int H_SYNC  = `LCD_H_SYNC,  // hsync width
	parameter int H_BACK  = `LCD_H_BACK,  // h back porch
	parameter int H_DISP  = `LCD_H_DISP,  // visible width
	parameter int H_FRONT = `LCD_H_FRONT, // h front porch
	parameter int V_SYNC  = `LCD_V_SYNC,  // vsync lines
	parameter int V_BACK  = `LCD_V_BACK,  // v back porch
	parameter int V_DISP  = `LCD_V_DISP,  // visible lines
	parameter int V_FRONT = `LCD_V_FRONT  // v front porch
)
(
	input  logic              clk,         // pixel clock, from outside
	input  logic              rst_n,       // async, active low
	input  lcd_pkg::pattern_e pattern_sel, // applied at next frame
	input  lcd_pkg::rgb_t     solid_color, // used by PAT_SOLID
	output logic              lcd_dclk,    // panel pins
	output logic              lcd_hs,
	output logic              lcd_vs,
	output logic              lcd_en,
	output lcd_pkg::rgb_t     lcd_rgb      // black when lcd_en low
);

	import lcd_pkg::*;

	logic   req;         // early enable
	coord_t xpos;        // next pixel x
	coord_t ypos;        // next pixel y
	logic   frame_start; // origin pulse
	rgb_t   pixel;       // pattern output, aligned to lcd_en

	lcd_timing
	#(
		.H_SYNC  (H_SYNC),
		.H_BACK  (H_BACK),
		.H_DISP  (H_DISP),
		.H_FRONT (H_FRONT),
		.V_SYNC  (V_SYNC),
		.V_BACK  (V_BACK),
		.V_DISP  (V_DISP),
		.V_FRONT (V_FRONT)
	)
	i_timing
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.lcd_dclk    (lcd_dclk),
		.lcd_hs      (lcd_hs),
		.lcd_vs      (lcd_vs),
		.lcd_en      (lcd_en),
		.req         (req),
		.xpos        (xpos),
		.ypos        (ypos),
		.frame_start (frame_start)
	);

	pattern_gen
	#(
		.H_DISP (H_DISP) // bar width only
	)
	i_pattern
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.xpos        (xpos),
		.ypos        (ypos),
		.frame_start (frame_start),
		.pattern_sel (pattern_sel),
		.solid_color (solid_color),
		.pixel       (pixel)
	);

	assign lcd_rgb = lcd_en ? pixel : '0; // blank in porches and sync

endmodule

`default_nettype wire

// ==== hdl/lcd_pkg.sv ====
`default_nettype none

`include "lcd_cfg.svh"

package lcd_pkg;

	// red [23:16], green [15:8], blue [7:0]
	typedef logic [`LCD_RGB_W-1:0] rgb_t;

	// screen coordinate or raw raster count
	typedef logic [`LCD_COORD_W-1:0] coord_t;

	// test pattern opcode
	typedef enum logic [1:0]
	{
		PAT_BARS     = 2'd0, // vertical colour bars
		PAT_GRID     = 2'd1, // white grid on black
		PAT_GRADIENT = 2'd2, // x/y ramps
		PAT_SOLID    = 2'd3  // external solid colour
	} pattern_e;

	// standard bar order, left to right
	localparam rgb_t BAR_COLORS [`LCD_BAR_COUNT] = '{
		24'hFF_FF_FF, // white
		24'hFF_FF_00, // yellow
		24'h00_FF_FF, // cyan
		24'h00_FF_00, // green
		24'hFF_00_FF, // magenta
		24'hFF_00_00, // red
		24'h00_00_FF, // blue
		24'h00_00_00  // black
	};

endpackage

`default_nettype wire

// ==== hdl/lcd_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_timing
#(
	parameter int H_SYNC  = `LCD_H_SYNC,  // hsync width
	parameter int H_BACK  = `LCD_H_BACK,  // h back porch
	parameter int H_DISP  = `LCD_H_DISP,  // visible width
	parameter int H_FRONT = `LCD_H_FRONT, // h front porch
	parameter int V_SYNC  = `LCD_V_SYNC,  // vsync lines
	parameter int V_BACK  = `LCD_V_BACK,  // v back porch
	parameter int V_DISP  = `LCD_V_DISP,  // visible lines
	parameter int V_FRONT = `LCD_V_FRONT  // v front porch
)
(
	input  logic            clk,         // pixel clock
	input  logic            rst_n,       // async, active low
	output logic            lcd_dclk,    // panel clock, inverted
	output logic            lcd_hs,      // active low hsync
	output logic            lcd_vs,      // active low vsync
	output logic            lcd_en,      // display enable
	output logic            req,         // enable window one clock early
	output lcd_pkg::coord_t xpos,        // next pixel x
	output lcd_pkg::coord_t ypos,        // next pixel y
	output logic            frame_start  // one clock at raster origin
);

	import lcd_pkg::*;

	localparam int H_TOTAL = H_SYNC + H_BACK + H_DISP + H_FRONT; // clocks per line
	localparam int V_TOTAL = V_SYNC + V_BACK + V_DISP + V_FRONT; // lines per frame
	localparam int AHEAD   = `LCD_AHEAD;                         // coordinate lead

	localparam coord_t H_LAST   = coord_t'(H_TOTAL - 1);          // last hcnt of a line
	localparam coord_t V_LAST   = coord_t'(V_TOTAL - 1);          // last line of a frame
	localparam coord_t H_SYNC_C = coord_t'(H_SYNC);
	localparam coord_t V_SYNC_C = coord_t'(V_SYNC);
	localparam coord_t H_START  = coord_t'(H_SYNC + H_BACK);      // first visible clock
	localparam coord_t H_END    = coord_t'(H_SYNC + H_BACK + H_DISP);
	localparam coord_t V_START  = coord_t'(V_SYNC + V_BACK);      // first visible line
	localparam coord_t V_END    = coord_t'(V_SYNC + V_BACK + V_DISP);
	localparam coord_t R_START  = coord_t'(H_SYNC + H_BACK - AHEAD); // request window
	localparam coord_t R_END    = coord_t'(H_SYNC + H_BACK + H_DISP - AHEAD);

	coord_t hcnt;   // clock within line
	coord_t vcnt;   // line within frame
	logic   h_wrap; // last clock of the line
	logic   h_act;  // horizontal visible window
	logic   h_req;  // horizontal window, shifted early
	logic   v_act;  // vertical visible window

	assign h_wrap = (hcnt == H_LAST);

	// free running pixel counter
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			hcnt <= '0;
		else if (h_wrap)
			hcnt <= '0; // line over
		else
			hcnt <= hcnt + 1'b1;
	end

	// line counter, steps on line wrap
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			vcnt <= '0;
		else if (h_wrap)
		begin
			if (vcnt == V_LAST)
				vcnt <= '0; // frame over
			else
				vcnt <= vcnt + 1'b1;
		end
	end

	// sync pulses, low at the start of line / frame
	assign lcd_hs = (hcnt >= H_SYNC_C);
	assign lcd_vs = (vcnt >= V_SYNC_C);

	// windows decoded straight from the counters
	assign h_act = (hcnt >= H_START) && (hcnt < H_END);
	assign h_req = (hcnt >= R_START) && (hcnt < R_END);
	assign v_act = (vcnt >= V_START) && (vcnt < V_END);

	assign lcd_en = h_act && v_act;
	assign req    = h_req && v_act; // same lines, earlier clocks

	// coords of the pixel shown next clock, zero when idle
	assign xpos = req ? (hcnt - R_START) : '0;
	assign ypos = req ? (vcnt - V_START) : '0;

	assign frame_start = (hcnt == '0) && (vcnt == '0); // origin of sync region

	assign lcd_dclk = ~clk; // panel samples on our falling edge

endmodule

`default_nettype wire

// ==== hdl/pattern_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module pattern_gen
#(
	parameter int H_DISP = `LCD_H_DISP // visible width, sets bar width
)
(
	input  logic              clk,         // pixel clock
	input  logic              rst_n,       // async, active low
	input  logic              req,         // coords valid this clock
	input  lcd_pkg::coord_t   xpos,        // requested x
	input  lcd_pkg::coord_t   ypos,        // requested y
	input  logic              frame_start, // raster origin pulse
	input  lcd_pkg::pattern_e pattern_sel, // wanted pattern, any time
	input  lcd_pkg::rgb_t     solid_color, // colour for PAT_SOLID
	output lcd_pkg::rgb_t     pixel        // one clock after req
);

	import lcd_pkg::*;

	localparam int BAR_LOG2  = `LCD_BAR_LOG2;  // log2 of bar count
	localparam int GRID_LOG2 = `LCD_GRID_LOG2; // log2 of grid pitch
	localparam int SCALED_W  = $bits(coord_t) + BAR_LOG2; // x * bars

	localparam logic [SCALED_W-1:0] BAR_DIV = SCALED_W'(H_DISP); // divisor

	pattern_e              active;     // pattern of the current frame
	logic [SCALED_W-1:0]   bar_scaled; // x times bar count
	logic [SCALED_W-1:0]   bar_quot;   // scaled x over width
	logic [BAR_LOG2-1:0]   bar_idx;    // 0..7 across the line
	rgb_t                  bar_rgb;    // table lookup
	logic                  grid_on;    // on a grid line
	rgb_t                  grid_rgb;
	rgb_t                  grad_rgb;
	rgb_t                  pixel_next; // combinational pick

	// pattern only switches at the raster origin
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			active <= PAT_BARS;
		else if (frame_start)
			active <= pattern_sel; // held for the whole frame
	end

	// bars: idx = x*8 / H_DISP
	assign bar_scaled = {xpos, {BAR_LOG2{1'b0}}};
	assign bar_quot   = bar_scaled / BAR_DIV; // constant divisor
	assign bar_idx    = bar_quot[BAR_LOG2-1:0]; // x < H_DISP keeps it in range
	assign bar_rgb    = BAR_COLORS[bar_idx];

	// grid: white on every 2**GRID_LOG2 row and column
	assign grid_on  = (xpos[GRID_LOG2-1:0] == '0) || (ypos[GRID_LOG2-1:0] == '0);
	assign grid_rgb = grid_on ? 24'hFF_FF_FF : 24'h00_00_00;

	// gradient: r = x, g = y, b = x ^ y, low bytes
	assign grad_rgb = {xpos[7:0], ypos[7:0], xpos[7:0] ^ ypos[7:0]};

	// select by the latched opcode
	always_comb
	begin
		unique case (active)
			PAT_BARS:     pixel_next = bar_rgb;
			PAT_GRID:     pixel_next = grid_rgb;
			PAT_GRADIENT: pixel_next = grad_rgb;
			PAT_SOLID:    pixel_next = solid_color;
			default:      pixel_next = '0;
		endcase
	end

	// one stage of latency, lines up with lcd_en
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			pixel <= '0;
		else if (req)
			pixel <= pixel_next;
		else
			pixel <= '0; // black outside the window
	end

endmodule

`default_nettype wire

// ==== lcd_display_top.f ====
+incdir+hdl
hdl/lcd_pkg.sv
hdl/lcd_timing.sv
hdl/pattern_gen.sv
hdl/lcd_display_top.sv
test/lcd_display_tb.sv

// ==== test/lcd_display_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lcd_cfg.svh"

module lcd_display_tb;

	import lcd_pkg::*;

	// small raster keeps a frame near 1000 clocks
	localparam int H_SYNC  = 4;
	localparam int H_BACK  = 3;
	localparam int H_DISP  = 32;
	localparam int H_FRONT = 2;
	localparam int V_SYNC  = 2;
	localparam int V_BACK  = 2;
	localparam int V_DISP  = 20;
	localparam int V_FRONT = 1;

	localparam int H_TOTAL    = H_SYNC + H_BACK + H_DISP + H_FRONT; // 41 clocks
	localparam int V_TOTAL    = V_SYNC + V_BACK + V_DISP + V_FRONT; // 25 lines
	localparam int FRAME_CLKS = H_TOTAL * V_TOTAL;
	localparam int GRID_PITCH = 1 << `LCD_GRID_LOG2;

	logic     clk;
	logic     rst_n;
	pattern_e pattern_sel;
	rgb_t     solid_color;
	logic     lcd_dclk;
	logic     lcd_hs;
	logic     lcd_vs;
	logic     lcd_en;
	rgb_t     lcd_rgb;

	integer   seed;         // $random state

	// monitor state
	int       x;            // enabled clocks so far in this line
	int       y;            // enabled lines so far in this frame
	int       line_len;     // clocks since line start
	int       hs_low;       // hsync low clocks in this line
	int       vs_low_lines; // line starts seen with vsync low
	int       line_cnt;     // lines in this frame
	int       frames_done;  // frames fully checked
	logic     prev_hs;
	logic     prev_vs;
	logic     prev_en;
	logic     started;      // raster tracking running
	logic     fresh;        // first clock after reset
	logic     new_line;
	logic     new_frame;
	pattern_e frame_pat;    // pattern expected in this frame

	lcd_display_top
	#(
		.H_SYNC  (H_SYNC),
		.H_BACK  (H_BACK),
		.H_DISP  (H_DISP),
		.H_FRONT (H_FRONT),
		.V_SYNC  (V_SYNC),
		.V_BACK  (V_BACK),
		.V_DISP  (V_DISP),
		.V_FRONT (V_FRONT)
	)
	i_dut
	(
		.clk         (clk),
		.rst_n       (rst_n),
		.pattern_sel (pattern_sel),
		.solid_color (solid_color),
		.lcd_dclk    (lcd_dclk),
		.lcd_hs      (lcd_hs),
		.lcd_vs      (lcd_vs),
		.lcd_en      (lcd_en),
		.lcd_rgb     (lcd_rgb)
	);

	initial
		clk = 1'b0;

	always #4 clk = ~clk; // 8 ns period

	// expected colour of screen pixel (x, y)
	function automatic rgb_t ref_pixel(input coord_t px, input coord_t py,
		input pattern_e pat, input rgb_t solid);
		logic [2:0] bar;
		logic       on_grid;
		rgb_t       res;
		bar     = 3'((int'(px) * 8) / H_DISP); // eight equal bars
		on_grid = ((int'(px) % GRID_PITCH) == 0) || ((int'(py) % GRID_PITCH) == 0);
		case (pat)
			PAT_BARS:     res = BAR_COLORS[bar];
			PAT_GRID:     res = on_grid ? 24'hFF_FF_FF : 24'h00_00_00;
			PAT_GRADIENT: res = {px[7:0], py[7:0], px[7:0] ^ py[7:0]};
			PAT_SOLID:    res = solid;
			default:      res = '0;
		endcase
		return res;
	endfunction

	task automatic stop_run();
		$display("Something failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_rgb(input rgb_t got, input rgb_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERROR %0d ns: %s got %06h expected %06h", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_coord(input coord_t got, input coord_t exp, input string what);
		if (got !== exp)
		begin
			$display("ERROR %0d ns: %s got %0d expected %0d", $time, what, got, exp);
			stop_run();
		end
	endtask

	task automatic check_level(input logic got, input logic exp, input string what);
		if (got !== exp)
		begin
			$display("ERROR %0d ns: %s got %b expected %b", $time, what, got, exp);
			stop_run();
		end
	endtask

	// returns 1 ns after the edge that ends the frame origin clock
	task automatic wait_vs_fall(input int limit);
		int   n;
		logic last;
		logic found;
		n     = 0;
		found = 1'b0;
		@(negedge clk);
		last = lcd_vs;
		while (!found && n < limit)
		begin
			@(negedge clk);
			found = last && !lcd_vs;
			last  = lcd_vs;
			n++;
		end
		if (!found)
		begin
			$display("timeout: lcd_vs never fell within %0d clocks", limit);
			stop_run();
		end
		@(posedge clk);
		#1;
	endtask

	// first enabled clock of the next active line
	task automatic wait_en_rise(input int limit);
		int   n;
		logic last;
		logic found;
		n     = 0;
		found = 1'b0;
		@(negedge clk);
		last = lcd_en;
		while (!found && n < limit)
		begin
			@(negedge clk);
			found = !last && lcd_en;
			last  = lcd_en;
			n++;
		end
		if (!found)
		begin
			$display("timeout: lcd_en never rose within %0d clocks", limit);
			stop_run();
		end
		@(posedge clk);
		#1;
	endtask

	// panel clock follows clk inverted, looked at 1 ns after each edge
	always @(clk)
	begin
		#1;
		check_level(lcd_dclk, !clk, "lcd_dclk"); // both phases
	end

	// raster tracking and compare, outputs settled at the falling edge
	always @(negedge clk)
	begin
		if (!rst_n)
		begin
			check_level(lcd_en, 1'b0, "lcd_en in reset");
			check_rgb(lcd_rgb, '0, "lcd_rgb in reset");
			check_level(lcd_hs, 1'b0, "lcd_hs in reset");
			check_level(lcd_vs, 1'b0, "lcd_vs in reset");
			started     = 1'b0;
			frames_done = 0;
		end
		else
		begin
			fresh     = !started;
			new_line  = fresh || (prev_hs && !lcd_hs); // hsync falls at line start
			new_frame = fresh || (prev_vs && !lcd_vs);
			if (new_frame)
			begin
				if (!fresh)
				begin
					check_coord(coord_t'(line_cnt), coord_t'(V_TOTAL), "lines per frame");
					check_coord(coord_t'(y), coord_t'(V_DISP), "enabled lines per frame");
					frames_done++;
				end
				frame_pat    = pattern_sel; // what the DUT latches this clock
				y            = 0;
				line_cnt     = 0;
				vs_low_lines = 0;
			end
			if (new_line)
			begin
				if (!fresh)
					check_coord(coord_t'(line_len), coord_t'(H_TOTAL), "clocks per line");
				line_len = 0;
				hs_low   = 0;
				x        = 0;
				line_cnt++;
				if (!lcd_vs)
					vs_low_lines++;
			end
			if (!lcd_hs)
				hs_low++;
			if (!fresh && !prev_hs && lcd_hs)
				check_coord(coord_t'(hs_low), coord_t'(H_SYNC), "hsync low clocks");
			if (!fresh && !prev_vs && lcd_vs)
				check_coord(coord_t'(vs_low_lines), coord_t'(V_SYNC), "vsync low lines");
			if (lcd_en)
			begin
				if (!fresh && !prev_en)
					check_coord(coord_t'(x), coord_t'(0), "second enable run in line");
				check_rgb(lcd_rgb,
					ref_pixel(coord_t'(x), coord_t'(y), frame_pat, solid_color),
					$sformatf("pixel x=%0d y=%0d", x, y));
				x++;
			end
			else
			begin
				check_rgb(lcd_rgb, '0, "lcd_rgb outside enable");
				if (!fresh && prev_en)
				begin
					check_coord(coord_t'(x), coord_t'(H_DISP), "enable run length");
					y++;
				end
			end
			line_len++;
			prev_hs = lcd_hs;
			prev_vs = lcd_vs;
			prev_en = lcd_en;
			started = 1'b1;
		end
	end

	initial
	begin
		seed        = 69;
		rst_n       = 1'b0;
		pattern_sel = PAT_BARS;
		solid_color = rgb_t'($random(seed));
		repeat (8) @(posedge clk);
		#1 rst_n = 1'b1;

		// frame 0 is bars, grid requested part way through it
		repeat (10) wait_en_rise(FRAME_CLKS);
		pattern_sel = PAT_GRID;

		wait_vs_fall(2 * FRAME_CLKS); // frame 1, grid
		pattern_sel = PAT_GRADIENT;
		wait_vs_fall(2 * FRAME_CLKS); // frame 2, gradient
		pattern_sel = PAT_SOLID;
		wait_vs_fall(2 * FRAME_CLKS); // frame 3, solid

		// mid frame switch back to bars
		repeat (7) wait_en_rise(FRAME_CLKS);
		pattern_sel = PAT_BARS;

		wait_vs_fall(2 * FRAME_CLKS); // frame 4, bars
		wait_vs_fall(2 * FRAME_CLKS); // frame 4 closed by the monitor

		check_coord(coord_t'(frames_done), coord_t'(5), "frames checked");
		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire
